//--- st_consts.svh
`ifndef ST_CONSTS_SVH
`define ST_CONSTS_SVH

// stream datapath geometry
`define ST_DATA_W   64
`define ST_BYTES    8
`define ST_PATT_W   16

// seed of the h2c back-pressure lfsr
`define ST_BP_SEED  16'h0011

// axi4-lite register offsets
`define ST_REG_CTRL      8'h00
`define ST_REG_H2C_SIZE  8'h04
`define ST_REG_C2H_SIZE  8'h08
`define ST_REG_C2H_PKTS  8'h0C
`define ST_REG_STATUS    8'h10
`define ST_REG_H2C_BEATS 8'h14
`define ST_REG_C2H_SENT  8'h18

`endif

//--- st_pkg.sv
`include "st_consts.svh"

package st_pkg;

   // h2c sideband, only the end-of-packet fields are kept
   typedef struct packed {
      logic [2:0] mty;
      logic       zero_byte;
   } h2c_user_t;

   // one h2c beat as seen by the pipe and the checker
   typedef struct packed {
      logic [`ST_DATA_W-1:0] data;
      logic                  last;
      h2c_user_t             user;
   } h2c_beat_t;

   // one c2h beat, mty is only meaningful with last
   typedef struct packed {
      logic [`ST_DATA_W-1:0] data;
      logic                  last;
      logic [2:0]            mty;
   } c2h_beat_t;

endpackage

//--- st_regs_pkg.sv
package st_regs_pkg;

   // control fields, clr is a single-cycle pulse
   typedef struct packed {
      logic        c2h_run;
      logic        bp_en;
      logic        clr;
      logic [31:0] h2c_txr_size;
      logic [31:0] c2h_txr_size;
      logic [15:0] c2h_pkts;
   } ctrl_t;

   // checker results, updated after each last beat
   typedef struct packed {
      logic        match;
      logic        fail;
      logic        size_match;
      logic [31:0] beats;
   } h2c_stat_t;

   // generator progress
   typedef struct packed {
      logic        busy;
      logic        done;
      logic [15:0] sent;
   } c2h_stat_t;

endpackage

//--- st_pipe_reg.sv
`timescale 1ns/1ps

module st_pipe_reg #(
   parameter type payload_t = logic
) (
   input  logic     axi_aclk,
   input  logic     axi_aresetn,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready
);

   logic full;

   // free slot, or the held item leaves this cycle
   assign in_ready  = !full || out_ready;
   assign out_valid = full;

   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         full <= 1'b0;
      end else if (in_ready) begin
         full <= in_valid;
      end
   end

   // payload slot
   always_ff @(posedge axi_aclk) begin
      if (in_valid && in_ready) begin
         out_data <= in_data;
      end
   end

endmodule

//--- st_h2c_checker.sv
`timescale 1ns/1ps
`include "st_consts.svh"

module st_h2c_checker (
   input  logic                   axi_aclk,
   input  logic                   axi_aresetn,
   input  st_pkg::h2c_beat_t      beat,
   input  logic                   valid,
   output logic                   ready,
   input  st_regs_pkg::ctrl_t     ctrl,
   output st_regs_pkg::h2c_stat_t stat
);

   localparam int NUM_WORDS  = `ST_DATA_W / `ST_PATT_W;
   localparam int WORD_BYTES = `ST_PATT_W / 8;

   typedef logic [`ST_PATT_W-1:0] word_t;

   word_t [NUM_WORDS-1:0] exp_word;
   logic [`ST_BYTES-1:0]  byte_ok;
   logic [3:0]            beat_bytes;
   logic                  accept;
   logic                  mismatch;
   logic [15:0]           lfsr;
   logic                  lfsr_fb;
   logic [31:0]           beat_cnt;
   logic [31:0]           byte_cnt;
   logic [31:0]           beats_total;
   logic [31:0]           bytes_total;

   assign lfsr_fb = lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5];

   // random back-pressure
   assign ready  = !(ctrl.bp_en && lfsr[0]);
   assign accept = valid && ready;

   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         lfsr <= `ST_BP_SEED;
      end else if (ctrl.bp_en) begin
         lfsr <= {lfsr_fb, lfsr[15:1]};
      end
   end

   // valid bytes in this beat, zero-byte beats carry none
   always_comb begin
      if (beat.user.zero_byte) begin
         beat_bytes = 4'd0;
      end else if (beat.last) begin
         beat_bytes = 4'(`ST_BYTES) - {1'b0, beat.user.mty};
      end else begin
         beat_bytes = 4'(`ST_BYTES);
      end
   end

   // byte k sits in word k/2, low byte first
   always_comb begin
      for (int k = 0; k < `ST_BYTES; k++) begin
         byte_ok[k] = (k >= beat_bytes) ||
                      (beat.data[8*k +: 8] == exp_word[k/WORD_BYTES][8*(k%WORD_BYTES) +: 8]);
      end
   end

   assign mismatch    = accept && !(&byte_ok);
   assign beats_total = beat_cnt + 32'd1;
   assign bytes_total = byte_cnt + 32'(beat_bytes);

   // expected pattern, carried across packets until clr
   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn || ctrl.clr) begin
         for (int j = 0; j < NUM_WORDS; j++) begin
            exp_word[j] <= word_t'(j);
         end
      end else if (accept && !beat.user.zero_byte) begin
         for (int j = 0; j < NUM_WORDS; j++) begin
            exp_word[j] <= exp_word[j] + word_t'(NUM_WORDS);
         end
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn || ctrl.clr) begin
         beat_cnt        <= '0;
         byte_cnt        <= '0;
         stat.fail       <= 1'b0;
         stat.match      <= 1'b0;
         stat.size_match <= 1'b1;
         stat.beats      <= '0;
      end else if (accept) begin
         // sticky until clr
         if (mismatch) begin
            stat.fail <= 1'b1;
         end
         if (beat.last) begin
            beat_cnt        <= '0;
            byte_cnt        <= '0;
            stat.match      <= !(stat.fail || mismatch);
            stat.size_match <= (bytes_total == ctrl.h2c_txr_size);
            stat.beats      <= beats_total;
         end else begin
            beat_cnt <= beats_total;
            byte_cnt <= bytes_total;
         end
      end
   end

endmodule

//--- st_c2h_gen.sv
`timescale 1ns/1ps
`include "st_consts.svh"

module st_c2h_gen (
   input  logic                   axi_aclk,
   input  logic                   axi_aresetn,
   input  st_regs_pkg::ctrl_t     ctrl,
   output st_pkg::c2h_beat_t      beat,
   output logic                   valid,
   input  logic                   ready,
   output st_regs_pkg::c2h_stat_t stat
);

   localparam int NUM_WORDS = `ST_DATA_W / `ST_PATT_W;

   typedef logic [`ST_PATT_W-1:0] word_t;

   word_t [NUM_WORDS-1:0] pat_word;
   logic                  run_d;
   logic                  run_rise;
   logic                  accept;
   logic                  last_beat;
   logic [32:0]           size_ceil;
   logic [29:0]           pkt_beats;
   logic [29:0]           beat_idx;
   logic [2:0]            pad;
   logic [15:0]           pkt_target;

   assign run_rise  = ctrl.c2h_run && !run_d;
   assign accept    = valid && ready;
   assign size_ceil = {1'b0, ctrl.c2h_txr_size} + 33'd7;
   assign last_beat = (beat_idx == pkt_beats - 30'd1);

   assign valid     = stat.busy;
   assign beat.data = pat_word;
   assign beat.last = last_beat;
   assign beat.mty  = last_beat ? pad : 3'd0;

   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         run_d      <= 1'b0;
         stat.busy  <= 1'b0;
         stat.done  <= 1'b0;
         stat.sent  <= '0;
         beat_idx   <= '0;
         pkt_beats  <= 30'd1;
         pad        <= 3'd0;
         pkt_target <= '0;
         for (int j = 0; j < NUM_WORDS; j++) begin
            pat_word[j] <= word_t'(j);
         end
      end else begin
         run_d <= ctrl.c2h_run;
         if (ctrl.clr) begin
            // abort and rewind
            stat.busy <= 1'b0;
            stat.done <= 1'b0;
            stat.sent <= '0;
            beat_idx  <= '0;
            for (int j = 0; j < NUM_WORDS; j++) begin
               pat_word[j] <= word_t'(j);
            end
         end else if (run_rise) begin
            // latch the job, a zero size sends one full beat
            stat.busy  <= (ctrl.c2h_pkts != 16'd0);
            stat.done  <= (ctrl.c2h_pkts == 16'd0);
            stat.sent  <= '0;
            beat_idx   <= '0;
            pkt_beats  <= (size_ceil[32:3] == 30'd0) ? 30'd1 : size_ceil[32:3];
            pad        <= 3'd0 - ctrl.c2h_txr_size[2:0];
            pkt_target <= ctrl.c2h_pkts;
            for (int j = 0; j < NUM_WORDS; j++) begin
               pat_word[j] <= word_t'(j);
            end
         end else if (accept) begin
            // pattern moves only on taken beats
            for (int j = 0; j < NUM_WORDS; j++) begin
               pat_word[j] <= pat_word[j] + word_t'(NUM_WORDS);
            end
            if (last_beat) begin
               beat_idx  <= '0;
               stat.sent <= stat.sent + 16'd1;
               if (stat.sent + 16'd1 == pkt_target) begin
                  stat.busy <= 1'b0;
                  stat.done <= 1'b1;
               end
            end else begin
               beat_idx <= beat_idx + 30'd1;
            end
         end
      end
   end

endmodule

//--- st_axil_regs.sv
`timescale 1ns/1ps
`include "st_consts.svh"

module st_axil_regs (
   input  logic                   axi_aclk,
   input  logic                   axi_aresetn,
   input  logic [31:0]            s_axil_awaddr,
   input  logic                   s_axil_awvalid,
   output logic                   s_axil_awready,
   input  logic [31:0]            s_axil_wdata,
   input  logic [3:0]             s_axil_wstrb,
   input  logic                   s_axil_wvalid,
   output logic                   s_axil_wready,
   output logic [1:0]             s_axil_bresp,
   output logic                   s_axil_bvalid,
   input  logic                   s_axil_bready,
   input  logic [31:0]            s_axil_araddr,
   input  logic                   s_axil_arvalid,
   output logic                   s_axil_arready,
   output logic [31:0]            s_axil_rdata,
   output logic [1:0]             s_axil_rresp,
   output logic                   s_axil_rvalid,
   input  logic                   s_axil_rready,
   output st_regs_pkg::ctrl_t     ctrl,
   input  st_regs_pkg::h2c_stat_t h2c_stat,
   input  st_regs_pkg::c2h_stat_t c2h_stat
);

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   logic        wr_en;
   logic        rd_en;
   logic        wr_ok;
   logic        rd_ok;
   logic [7:0]  wr_off;
   logic [7:0]  rd_off;
   logic [31:0] rd_word;
   logic        run_q;
   logic        bp_q;
   logic        clr_q;
   logic [31:0] h2c_size_q;
   logic [31:0] c2h_size_q;
   logic [15:0] pkts_q;

   function automatic logic [31:0] apply_strb(input logic [31:0] old_val,
                                              input logic [31:0] new_val,
                                              input logic [3:0]  strb);
      logic [31:0] res;
      res = old_val;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            res[8*b +: 8] = new_val[8*b +: 8];
         end
      end
      return res;
   endfunction

   assign wr_off = s_axil_awaddr[7:0];
   assign rd_off = s_axil_araddr[7:0];

   // address and data are taken together
   assign wr_en          = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
   assign s_axil_awready = wr_en;
   assign s_axil_wready  = wr_en;

   assign s_axil_arready = !s_axil_rvalid;
   assign rd_en          = s_axil_arvalid && s_axil_arready;

   assign wr_ok = (wr_off == `ST_REG_CTRL)     || (wr_off == `ST_REG_H2C_SIZE) ||
                  (wr_off == `ST_REG_C2H_SIZE) || (wr_off == `ST_REG_C2H_PKTS);

   assign ctrl = '{c2h_run:      run_q,
                   bp_en:        bp_q,
                   clr:          clr_q,
                   h2c_txr_size: h2c_size_q,
                   c2h_txr_size: c2h_size_q,
                   c2h_pkts:     pkts_q};

   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         s_axil_bvalid <= 1'b0;
         s_axil_bresp  <= RESP_OKAY;
      end else if (wr_en) begin
         s_axil_bvalid <= 1'b1;
         s_axil_bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
      end else if (s_axil_bready) begin
         s_axil_bvalid <= 1'b0;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         run_q      <= 1'b0;
         bp_q       <= 1'b0;
         clr_q      <= 1'b0;
         h2c_size_q <= '0;
         c2h_size_q <= '0;
         pkts_q     <= '0;
      end else begin
         clr_q <= 1'b0;
         if (wr_en) begin
            case (wr_off)
               `ST_REG_CTRL: begin
                  if (s_axil_wstrb[0]) begin
                     run_q <= s_axil_wdata[0];
                     bp_q  <= s_axil_wdata[1];
                     // clear is a pulse, never held
                     clr_q <= s_axil_wdata[2];
                  end
               end
               `ST_REG_H2C_SIZE: h2c_size_q <= apply_strb(h2c_size_q, s_axil_wdata, s_axil_wstrb);
               `ST_REG_C2H_SIZE: c2h_size_q <= apply_strb(c2h_size_q, s_axil_wdata, s_axil_wstrb);
               `ST_REG_C2H_PKTS: begin
                  if (s_axil_wstrb[0]) begin
                     pkts_q[7:0] <= s_axil_wdata[7:0];
                  end
                  if (s_axil_wstrb[1]) begin
                     pkts_q[15:8] <= s_axil_wdata[15:8];
                  end
               end
               default: ;
            endcase
         end
      end
   end

   // read mux, status merged from both stream blocks
   always_comb begin
      rd_word = '0;
      rd_ok   = 1'b1;
      case (rd_off)
         `ST_REG_CTRL:      rd_word = {30'd0, bp_q, run_q};
         `ST_REG_H2C_SIZE:  rd_word = h2c_size_q;
         `ST_REG_C2H_SIZE:  rd_word = c2h_size_q;
         `ST_REG_C2H_PKTS:  rd_word = {16'd0, pkts_q};
         `ST_REG_STATUS:    rd_word = {27'd0, c2h_stat.busy, c2h_stat.done, h2c_stat.size_match,
                                       h2c_stat.fail, h2c_stat.match};
         `ST_REG_H2C_BEATS: rd_word = h2c_stat.beats;
         `ST_REG_C2H_SENT:  rd_word = {16'd0, c2h_stat.sent};
         default:           rd_ok   = 1'b0;
      endcase
   end

   always_ff @(posedge axi_aclk) begin
      if (!axi_aresetn) begin
         s_axil_rvalid <= 1'b0;
      end else if (rd_en) begin
         s_axil_rvalid <= 1'b1;
      end else if (s_axil_rready) begin
         s_axil_rvalid <= 1'b0;
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (rd_en) begin
         s_axil_rdata <= rd_word;
         s_axil_rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
      end
   end

endmodule

//--- st_top.sv
`timescale 1ns/1ps
`include "st_consts.svh"

module st_top (
   input  logic                  axi_aclk,
   input  logic                  axi_aresetn,
   input  logic [31:0]           s_axil_awaddr,
   input  logic                  s_axil_awvalid,
   output logic                  s_axil_awready,
   input  logic [31:0]           s_axil_wdata,
   input  logic [3:0]            s_axil_wstrb,
   input  logic                  s_axil_wvalid,
   output logic                  s_axil_wready,
   output logic [1:0]            s_axil_bresp,
   output logic                  s_axil_bvalid,
   input  logic                  s_axil_bready,
   input  logic [31:0]           s_axil_araddr,
   input  logic                  s_axil_arvalid,
   output logic                  s_axil_arready,
   output logic [31:0]           s_axil_rdata,
   output logic [1:0]            s_axil_rresp,
   output logic                  s_axil_rvalid,
   input  logic                  s_axil_rready,
   input  logic [`ST_DATA_W-1:0] h2c_tdata,
   input  logic                  h2c_tvalid,
   input  logic                  h2c_tlast,
   input  st_pkg::h2c_user_t     h2c_tuser,
   output logic                  h2c_tready,
   output logic [`ST_DATA_W-1:0] c2h_tdata,
   output logic                  c2h_tvalid,
   output logic                  c2h_tlast,
   output logic [2:0]            c2h_mty,
   input  logic                  c2h_tready
);

   st_regs_pkg::ctrl_t     ctrl;
   st_regs_pkg::h2c_stat_t h2c_stat;
   st_regs_pkg::c2h_stat_t c2h_stat;
   st_pkg::h2c_beat_t      h2c_in;
   st_pkg::h2c_beat_t      h2c_beat;
   logic                   h2c_valid;
   logic                   h2c_ready;
   st_pkg::c2h_beat_t      c2h_beat;
   st_pkg::c2h_beat_t      c2h_out;
   logic                   c2h_valid;
   logic                   c2h_ready;

   assign h2c_in = '{data: h2c_tdata, last: h2c_tlast, user: h2c_tuser};

   assign c2h_tdata = c2h_out.data;
   assign c2h_tlast = c2h_out.last;
   assign c2h_mty   = c2h_out.mty;

   st_axil_regs u_regs (
      .axi_aclk, .axi_aresetn,
      .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
      .s_axil_wdata, .s_axil_wstrb, .s_axil_wvalid, .s_axil_wready,
      .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
      .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
      .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
      .ctrl, .h2c_stat, .c2h_stat
   );

   // h2c port register
   st_pipe_reg #(.payload_t(st_pkg::h2c_beat_t)) u_h2c_pipe (
      .axi_aclk, .axi_aresetn,
      .in_data  (h2c_in),
      .in_valid (h2c_tvalid),
      .in_ready (h2c_tready),
      .out_data (h2c_beat),
      .out_valid(h2c_valid),
      .out_ready(h2c_ready)
   );

   st_h2c_checker u_checker (
      .axi_aclk, .axi_aresetn,
      .beat (h2c_beat),
      .valid(h2c_valid),
      .ready(h2c_ready),
      .ctrl,
      .stat (h2c_stat)
   );

   st_c2h_gen u_gen (
      .axi_aclk, .axi_aresetn,
      .ctrl,
      .beat (c2h_beat),
      .valid(c2h_valid),
      .ready(c2h_ready),
      .stat (c2h_stat)
   );

   // c2h port register
   st_pipe_reg #(.payload_t(st_pkg::c2h_beat_t)) u_c2h_pipe (
      .axi_aclk, .axi_aresetn,
      .in_data  (c2h_beat),
      .in_valid (c2h_valid),
      .in_ready (c2h_ready),
      .out_data (c2h_out),
      .out_valid(c2h_tvalid),
      .out_ready(c2h_tready)
   );

endmodule

//--- st_top_sva.sv
`timescale 1ns/1ps
`include "st_consts.svh"

module st_top_sva (
   input logic                  axi_aclk,
   input logic                  axi_aresetn,
   input logic                  s_axil_bvalid,
   input logic                  s_axil_bready,
   input logic                  s_axil_rvalid,
   input logic                  s_axil_rready,
   input logic [`ST_DATA_W-1:0] h2c_tdata,
   input logic                  h2c_tvalid,
   input logic                  h2c_tlast,
   input st_pkg::h2c_user_t     h2c_tuser,
   input logic                  h2c_tready,
   input logic [`ST_DATA_W-1:0] c2h_tdata,
   input logic                  c2h_tvalid,
   input logic                  c2h_tlast,
   input logic [2:0]            c2h_mty,
   input logic                  c2h_tready
);

   // a stalled h2c beat stays put
   h2c_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      h2c_tvalid && !h2c_tready |=> h2c_tvalid && $stable(h2c_tdata) &&
                                    $stable(h2c_tlast) && $stable(h2c_tuser))
      else $error("h2c beat changed while stalled");

   // same rule on the c2h side
   c2h_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      c2h_tvalid && !c2h_tready |=> c2h_tvalid && $stable(c2h_tdata) &&
                                    $stable(c2h_tlast) && $stable(c2h_mty))
      else $error("c2h beat changed while stalled");

   bvalid_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
      else $error("bvalid dropped before bready");

   rvalid_hold: assert property (@(posedge axi_aclk) disable iff (!axi_aresetn)
      s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid)
      else $error("rvalid dropped before rready");

   c2h_quiet_in_reset: assert property (@(posedge axi_aclk)
      !axi_aresetn |=> !c2h_tvalid)
      else $error("c2h_tvalid high during reset");

endmodule

bind st_top st_top_sva u_sva (
   .axi_aclk, .axi_aresetn,
   .s_axil_bvalid, .s_axil_bready, .s_axil_rvalid, .s_axil_rready,
   .h2c_tdata, .h2c_tvalid, .h2c_tlast, .h2c_tuser, .h2c_tready,
   .c2h_tdata, .c2h_tvalid, .c2h_tlast, .c2h_mty, .c2h_tready
);

//--- tb_st_top.sv
`timescale 1ns/1ps
`include "st_consts.svh"

module tb_st_top;

   localparam int         TIMEOUT     = 1000;
   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   logic                  axi_aclk;
   logic                  axi_aresetn;
   logic [31:0]           s_axil_awaddr;
   logic                  s_axil_awvalid;
   logic                  s_axil_awready;
   logic [31:0]           s_axil_wdata;
   logic [3:0]            s_axil_wstrb;
   logic                  s_axil_wvalid;
   logic                  s_axil_wready;
   logic [1:0]            s_axil_bresp;
   logic                  s_axil_bvalid;
   logic                  s_axil_bready;
   logic [31:0]           s_axil_araddr;
   logic                  s_axil_arvalid;
   logic                  s_axil_arready;
   logic [31:0]           s_axil_rdata;
   logic [1:0]            s_axil_rresp;
   logic                  s_axil_rvalid;
   logic                  s_axil_rready;
   logic [`ST_DATA_W-1:0] h2c_tdata;
   logic                  h2c_tvalid;
   logic                  h2c_tlast;
   st_pkg::h2c_user_t     h2c_tuser;
   logic                  h2c_tready;
   logic [`ST_DATA_W-1:0] c2h_tdata;
   logic                  c2h_tvalid;
   logic                  c2h_tlast;
   logic [2:0]            c2h_mty;
   logic                  c2h_tready;

   int   mism_cnt;
   int   fail_cnt;
   int   h2c_beat_base;
   int   h2c_stall_cnt;
   logic ref_fail;
   int   c2h_size;
   int   c2h_beat;
   int   c2h_stream_beat;
   int   c2h_pkts_seen;

   st_top u_dut (.*);

   initial begin
      axi_aclk = 1'b0;
      forever #4 axi_aclk = ~axi_aclk;
   end

   // byte idx of the stream is byte idx%2 of 16-bit word idx/2
   function automatic logic [7:0] patt_byte(input int unsigned idx);
      logic [15:0] word;
      word = 16'(idx >> 1);
      return idx[0] ? word[15:8] : word[7:0];
   endfunction

   task automatic compare_word(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
      if (got !== exp) begin
         mism_cnt++;
         $display("mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      end
   endtask

   task automatic report_timeout(input string what);
      fail_cnt++;
      $display("timeout while waiting for %s", what);
   endtask

   task automatic axil_write(input logic [7:0] off, input logic [31:0] data,
                             input logic [1:0] exp_resp);
      int cnt;
      s_axil_awaddr  = {24'd0, off};
      s_axil_wdata   = data;
      s_axil_awvalid = 1'b1;
      s_axil_wvalid  = 1'b1;
      for (cnt = 0; cnt < TIMEOUT; cnt++) begin
         @(posedge axi_aclk);
         if (s_axil_awready) break;
      end
      if (cnt == TIMEOUT) begin
         report_timeout("awready and wready");
      end else begin
         // wready rises together with awready
         compare_word("s_axil_wready", s_axil_wready, 32'h1);
      end
      #1;
      s_axil_awvalid = 1'b0;
      s_axil_wvalid  = 1'b0;
      for (cnt = 0; cnt < TIMEOUT; cnt++) begin
         @(posedge axi_aclk);
         if (s_axil_bvalid) break;
      end
      if (cnt == TIMEOUT) report_timeout("bvalid");
      compare_word("s_axil_bresp", {30'd0, s_axil_bresp}, {30'd0, exp_resp});
      // response waits one cycle before bready
      #1;
      s_axil_bready = 1'b1;
      @(posedge axi_aclk);
      #1;
      s_axil_bready = 1'b0;
   endtask

   task automatic axil_read(input logic [7:0] off, output logic [31:0] data,
                            input logic [1:0] exp_resp);
      int cnt;
      s_axil_araddr  = {24'd0, off};
      s_axil_arvalid = 1'b1;
      for (cnt = 0; cnt < TIMEOUT; cnt++) begin
         @(posedge axi_aclk);
         if (s_axil_arready) break;
      end
      if (cnt == TIMEOUT) report_timeout("arready");
      #1;
      s_axil_arvalid = 1'b0;
      for (cnt = 0; cnt < TIMEOUT; cnt++) begin
         @(posedge axi_aclk);
         if (s_axil_rvalid) break;
      end
      if (cnt == TIMEOUT) report_timeout("rvalid");
      data = s_axil_rdata;
      compare_word("s_axil_rresp", {30'd0, s_axil_rresp}, {30'd0, exp_resp});
      // read data also waits one cycle before rready
      #1;
      s_axil_rready = 1'b1;
      @(posedge axi_aclk);
      #1;
      s_axil_rready = 1'b0;
   endtask

   task automatic send_h2c_packet(input int nbytes, input int bad_idx);
      int         nbeats;
      int         cnt;
      int         pos;
      logic [7:0] val;
      nbeats = (nbytes + 7) / 8;
      for (int b = 0; b < nbeats; b++) begin
         h2c_tvalid = 1'b0;
         repeat ($urandom_range(0, 2)) begin
            @(posedge axi_aclk);
            #1;
         end
         for (int k = 0; k < `ST_BYTES; k++) begin
            pos = 8 * b + k;
            // bytes past the end are garbage
            if (pos >= nbytes) val = 8'($urandom);
            else val = patt_byte(8 * (h2c_beat_base + b) + k);
            if (pos == bad_idx) val = ~val;
            h2c_tdata[8*k +: 8] = val;
         end
         h2c_tvalid          = 1'b1;
         h2c_tlast           = (b == nbeats - 1);
         h2c_tuser.mty       = h2c_tlast ? 3'(8 * nbeats - nbytes) : 3'd0;
         h2c_tuser.zero_byte = 1'b0;
         for (cnt = 0; cnt < TIMEOUT; cnt++) begin
            @(posedge axi_aclk);
            if (h2c_tready) break;
         end
         if (cnt == TIMEOUT) report_timeout("h2c_tready");
         #1;
      end
      h2c_tvalid    = 1'b0;
      h2c_tlast     = 1'b0;
      h2c_beat_base = h2c_beat_base + nbeats;
   endtask

   task automatic run_h2c_packet(input int nbytes, input int txr_size, input int bad_idx);
      logic [31:0] rdata;
      logic [2:0]  exp_stat;
      int          cnt;
      axil_write(`ST_REG_H2C_SIZE, txr_size, RESP_OKAY);
      send_h2c_packet(nbytes, bad_idx);
      // status is final once the checker has drained the pipe
      for (cnt = 0; cnt < TIMEOUT; cnt++) begin
         @(posedge axi_aclk);
         if (!u_dut.h2c_valid) break;
      end
      if (cnt == TIMEOUT) report_timeout("h2c pipe to drain");
      #1;
      if (bad_idx >= 0) ref_fail = 1'b1;
      exp_stat = {(txr_size == nbytes), ref_fail, !ref_fail};
      axil_read(`ST_REG_STATUS, rdata, RESP_OKAY);
      compare_word("STATUS[2:0]", {29'd0, rdata[2:0]}, {29'd0, exp_stat});
      axil_read(`ST_REG_H2C_BEATS, rdata, RESP_OKAY);
      compare_word("H2C_BEATS", rdata, 32'((nbytes + 7) / 8));
   endtask

   task automatic run_c2h(input int size, input int pkts);
      logic [31:0] rdata;
      int          cnt;
      c2h_size        = size;
      c2h_beat        = 0;
      c2h_stream_beat = 0;
      c2h_pkts_seen   = 0;
      axil_write(`ST_REG_C2H_SIZE, size, RESP_OKAY);
      axil_write(`ST_REG_C2H_PKTS, pkts, RESP_OKAY);
      axil_write(`ST_REG_CTRL, 32'h1, RESP_OKAY);
      for (cnt = 0; cnt < TIMEOUT; cnt++) begin
         @(posedge axi_aclk);
         #1;
         if (c2h_pkts_seen == pkts) break;
      end
      if (cnt == TIMEOUT) report_timeout("all c2h packets");
      // done set, busy clear
      axil_read(`ST_REG_STATUS, rdata, RESP_OKAY);
      compare_word("STATUS[4:3]", {30'd0, rdata[4:3]}, 32'h1);
      axil_read(`ST_REG_C2H_SENT, rdata, RESP_OKAY);
      compare_word("C2H_SENT", rdata, pkts);
      axil_write(`ST_REG_CTRL, 32'h0, RESP_OKAY);
   endtask

   // random c2h sink stalls
   initial begin
      forever begin
         @(posedge axi_aclk);
         #1;
         c2h_tready = ($urandom_range(0, 3) != 0);
      end
   end

   always @(posedge axi_aclk) begin
      if (axi_aresetn && h2c_tvalid && !h2c_tready) h2c_stall_cnt++;
   end

   // c2h compare against the reference pattern
   always @(posedge axi_aclk) begin : c2h_compare
      int   nbeats;
      int   mty_exp;
      logic last_exp;
      if (axi_aresetn && c2h_tvalid && c2h_tready) begin
         nbeats   = (c2h_size + 7) / 8;
         last_exp = (c2h_beat == nbeats - 1);
         mty_exp  = last_exp ? 8 * nbeats - c2h_size : 0;
         if (c2h_tlast !== last_exp) begin
            mism_cnt++;
            $display("mismatch c2h_tlast: got 0x%0h, expected 0x%0h", c2h_tlast, last_exp);
         end
         if (c2h_mty !== 3'(mty_exp)) begin
            mism_cnt++;
            $display("mismatch c2h_mty: got 0x%0h, expected 0x%0h", c2h_mty, mty_exp);
         end
         for (int k = 0; k < `ST_BYTES - mty_exp; k++) begin
            if (c2h_tdata[8*k +: 8] !== patt_byte(8 * c2h_stream_beat + k)) begin
               mism_cnt++;
               $display("mismatch c2h_tdata byte %0d: got 0x%02h, expected 0x%02h", k,
                        c2h_tdata[8*k +: 8], patt_byte(8 * c2h_stream_beat + k));
            end
         end
         c2h_stream_beat++;
         if (last_exp) begin
            c2h_beat = 0;
            c2h_pkts_seen++;
         end else begin
            c2h_beat++;
         end
      end
   end

   initial begin : main
      logic [31:0] rdata;
      int          size;
      mism_cnt       = 0;
      fail_cnt       = 0;
      h2c_beat_base  = 0;
      h2c_stall_cnt  = 0;
      ref_fail       = 1'b0;
      c2h_size       = 8;
      c2h_beat       = 0;
      c2h_pkts_seen  = 0;
      axi_aresetn    = 1'b0;
      s_axil_awaddr  = '0;
      s_axil_awvalid = 1'b0;
      s_axil_wdata   = '0;
      s_axil_wstrb   = 4'hf;
      s_axil_wvalid  = 1'b0;
      s_axil_bready  = 1'b0;
      s_axil_araddr  = '0;
      s_axil_arvalid = 1'b0;
      s_axil_rready  = 1'b0;
      h2c_tdata      = '0;
      h2c_tvalid     = 1'b0;
      h2c_tlast      = 1'b0;
      h2c_tuser      = '0;
      c2h_tready     = 1'b0;
      void'($urandom(32'hd33c_b5bd));
      repeat (16) @(posedge axi_aclk);
      #1;
      axi_aresetn = 1'b1;

      // reset values
      compare_word("s_axil_bvalid", s_axil_bvalid, 32'h0);
      compare_word("s_axil_rvalid", s_axil_rvalid, 32'h0);
      compare_word("c2h_tvalid", c2h_tvalid, 32'h0);
      compare_word("h2c_tready", h2c_tready, 32'h1);
      axil_read(`ST_REG_STATUS, rdata, RESP_OKAY);
      compare_word("STATUS[4:1]", {28'd0, rdata[4:1]}, 32'h2);

      // clean packets
      for (int i = 0; i < 4; i++) begin
         size = $urandom_range(1, 64);
         run_h2c_packet(size, size, -1);
      end

      // one bad byte, sticky fail, then clr
      size = $urandom_range(1, 64);
      run_h2c_packet(size, size, $urandom_range(0, size - 1));
      size = $urandom_range(1, 64);
      run_h2c_packet(size, size, -1);
      axil_write(`ST_REG_CTRL, 32'h4, RESP_OKAY);
      ref_fail      = 1'b0;
      h2c_beat_base = 0;
      size = $urandom_range(1, 64);
      run_h2c_packet(size, size, -1);

      // lfsr back-pressure
      axil_write(`ST_REG_CTRL, 32'h2, RESP_OKAY);
      h2c_stall_cnt = 0;
      for (int i = 0; i < 4; i++) begin
         size = $urandom_range(9, 64);
         run_h2c_packet(size, size, -1);
      end
      if (h2c_stall_cnt == 0) begin
         fail_cnt++;
         $display("h2c_tready never dropped with back-pressure enabled");
      end
      axil_write(`ST_REG_CTRL, 32'h0, RESP_OKAY);

      // wrong size, read-only write, unmapped read
      size = $urandom_range(1, 64);
      run_h2c_packet(size, size + 3, -1);
      axil_write(`ST_REG_STATUS, 32'h1, RESP_SLVERR);
      axil_read(8'h40, rdata, RESP_SLVERR);
      compare_word("unmapped rdata", rdata, 32'h0);

      // generator runs under sink stalls
      for (int r = 0; r < 2; r++) begin
         run_c2h($urandom_range(1, 40), $urandom_range(1, 5));
      end

      $display("errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
      if (mism_cnt == 0 && fail_cnt == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

//--- flist.f
+incdir+.
st_pkg.sv
st_regs_pkg.sv
st_pipe_reg.sv
st_h2c_checker.sv
st_c2h_gen.sv
st_axil_regs.sv
st_top.sv
st_top_sva.sv
tb_st_top.sv

//--- Bender.yml
package:
  name: st_exerciser

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - st_pkg.sv
      - st_regs_pkg.sv
      - st_pipe_reg.sv
      - st_h2c_checker.sv
      - st_c2h_gen.sv
      - st_axil_regs.sv
      - st_top.sv
      - target: test
        files:
          - st_top_sva.sv
          - tb_st_top.sv
